//--- files.f
+incdir+include
src/mc_accel_pkg.sv
src/mc_rx_fifo.sv
src/mc_endpoint.sv
src/mc_accel_ctrl.sv
src/mc_accel_tile.sv
tb/mc_accel_chk.sv
tb/mc_accel_tb.sv

//--- include/mc_accel_params.svh
`ifndef MC_ACCEL_PARAMS_SVH
`define MC_ACCEL_PARAMS_SVH

// mesh coordinate widths
`define MC_X_WIDTH 4
`define MC_Y_WIDTH 4

// word address carried by a link packet
`define MC_ADDR_WIDTH 16

// payload width of one store
`define MC_DATA_WIDTH 32

// entries in the receive FIFO
`define MC_RX_FIFO_ELS 4

// stores that may be in flight before a credit comes back
`define MC_MAX_CREDITS 4

`endif

//--- src/mc_accel_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "mc_accel_params.svh"

module mc_accel_ctrl
(
   input  logic                     clk_i,
   input  logic                     rst_n_i,

   input  mc_accel_pkg::mc_cord_s   my_cord_i,

   // FIFO head
   input  logic                     req_v_i,
   input  mc_accel_pkg::mc_req_s    req_i,
   output logic                     req_yumi_o,

   // outgoing store
   output logic                     send_v_o,
   output mc_accel_pkg::mc_packet_s send_packet_o,
   input  logic                     send_ready_i,

   output logic                     freeze_o
);
   import mc_accel_pkg::*;

   logic [3:0]                reg_en;
   mc_cfg_word_u              in_word;
   logic [`MC_ADDR_WIDTH-1:0] dest_addr_r;
   mc_cord_s                  dest_cord_r;
   logic                      freeze_r;

   // one enable per register address, only while the head is valid
   always_comb
   begin
      reg_en = '0;
      if (req_v_i)
         reg_en[req_i.addr[1:0]] = 1'b1;
   end

   assign in_word.raw = req_i.data;

   // address 2 forwards the word, held at the head while frozen or out of credits
   assign send_v_o = reg_en[2] & ~freeze_r;

   // config writes never wait
   assign req_yumi_o = reg_en[0] | reg_en[1] | reg_en[3] | (send_v_o & send_ready_i);

   // address 0 sets the outgoing address
   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
         dest_addr_r <= '0;
      else if (reg_en[0])
         dest_addr_r <= in_word.addr_view.addr;
   end

   // address 1 sets the destination y/x
   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
         dest_cord_r <= '0;
      else if (reg_en[1])
         dest_cord_r <= in_word.cord_view.cord;
   end

   // address 3 writes freeze from bit 0; the tile comes up frozen
   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
         freeze_r <= 1'b1;
      else if (reg_en[3])
         freeze_r <= in_word.raw[0];
   end

   assign freeze_o = freeze_r;

   always_comb
   begin
      send_packet_o.op     = MC_OP_STORE;
      // all bytes written
      send_packet_o.op_ex  = 4'b1111;
      send_packet_o.addr   = dest_addr_r;
      send_packet_o.data   = in_word.raw;
      send_packet_o.y_cord = dest_cord_r.y_cord;
      send_packet_o.x_cord = dest_cord_r.x_cord;
      send_packet_o.src_y  = my_cord_i.y_cord;
      send_packet_o.src_x  = my_cord_i.x_cord;
   end

endmodule

`default_nettype wire

//--- src/mc_accel_pkg.sv
`default_nettype none

`include "mc_accel_params.svh"

package mc_accel_pkg;

   // only stores are generated by the tile
   typedef enum logic [1:0]
   {
      MC_OP_LOAD  = 2'b00,
      MC_OP_STORE = 2'b01
   } mc_op_e;

   typedef struct packed
   {
      logic [`MC_Y_WIDTH-1:0] y_cord;
      logic [`MC_X_WIDTH-1:0] x_cord;
   } mc_cord_s;

   typedef struct packed
   {
      mc_op_e                    op;
      // byte mask
      logic [3:0]                op_ex;
      logic [`MC_ADDR_WIDTH-1:0] addr;
      logic [`MC_DATA_WIDTH-1:0] data;
      logic [`MC_Y_WIDTH-1:0]    y_cord;
      logic [`MC_X_WIDTH-1:0]    x_cord;
      logic [`MC_Y_WIDTH-1:0]    src_y;
      logic [`MC_X_WIDTH-1:0]    src_x;
   } mc_packet_s;

   // what survives of a packet once it is in the receive FIFO
   typedef struct packed
   {
      logic [`MC_ADDR_WIDTH-1:0] addr;
      logic [`MC_DATA_WIDTH-1:0] data;
   } mc_req_s;

   typedef struct packed
   {
      logic [`MC_DATA_WIDTH-`MC_ADDR_WIDTH-1:0] pad;
      logic [`MC_ADDR_WIDTH-1:0]                addr;
   } mc_cfg_addr_s;

   typedef struct packed
   {
      logic [`MC_DATA_WIDTH-`MC_Y_WIDTH-`MC_X_WIDTH-1:0] pad;
      mc_cord_s                                          cord;
   } mc_cfg_cord_s;

   // one received word, read as an address or as a y/x pair
   typedef union packed
   {
      logic [`MC_DATA_WIDTH-1:0] raw;
      mc_cfg_addr_s              addr_view;
      mc_cfg_cord_s              cord_view;
   } mc_cfg_word_u;

endpackage

`default_nettype wire

//--- src/mc_accel_tile.sv
`timescale 1ns/10ps
`default_nettype none

module mc_accel_tile
(
   input  logic                     clk_i,
   input  logic                     rst_n_i,
   input  logic                     link_v_i,
   input  mc_accel_pkg::mc_packet_s link_packet_i,
   output logic                     link_ready_o,
   output logic                     link_v_o,
   output mc_accel_pkg::mc_packet_s link_packet_o,
   input  logic                     credit_i,
   input  mc_accel_pkg::mc_cord_s   my_cord_i,
   output logic                     freeze_o
);
   import mc_accel_pkg::*;

   logic       req_v;
   mc_req_s    req;
   logic       req_yumi;
   logic       send_v;
   mc_packet_s send_packet;
   logic       send_ready;

   mc_endpoint i_endpoint
   (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .link_v_i      (link_v_i),
      .link_packet_i (link_packet_i),
      .link_ready_o  (link_ready_o),
      .link_v_o      (link_v_o),
      .link_packet_o (link_packet_o),
      .credit_i      (credit_i),
      .req_v_o       (req_v),
      .req_o         (req),
      .req_yumi_i    (req_yumi),
      .send_v_i      (send_v),
      .send_packet_i (send_packet),
      .send_ready_o  (send_ready)
   );

   // decodes the FIFO head and builds the forwarded stores
   mc_accel_ctrl i_ctrl
   (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .my_cord_i     (my_cord_i),
      .req_v_i       (req_v),
      .req_i         (req),
      .req_yumi_o    (req_yumi),
      .send_v_o      (send_v),
      .send_packet_o (send_packet),
      .send_ready_i  (send_ready),
      .freeze_o      (freeze_o)
   );

endmodule

`default_nettype wire

//--- src/mc_endpoint.sv
`timescale 1ns/10ps
`default_nettype none

`include "mc_accel_params.svh"

module mc_endpoint
(
   input  logic                     clk_i,
   input  logic                     rst_n_i,

   // input link
   input  logic                     link_v_i,
   input  mc_accel_pkg::mc_packet_s link_packet_i,
   output logic                     link_ready_o,

   // output link, one strobe per store
   output logic                     link_v_o,
   output mc_accel_pkg::mc_packet_s link_packet_o,
   input  logic                     credit_i,

   // head of the receive FIFO
   output logic                     req_v_o,
   output mc_accel_pkg::mc_req_s    req_o,
   input  logic                     req_yumi_i,

   // send request from the controller
   input  logic                     send_v_i,
   input  mc_accel_pkg::mc_packet_s send_packet_i,
   output logic                     send_ready_o
);
   import mc_accel_pkg::*;

   localparam int unsigned MAX_CREDITS = `MC_MAX_CREDITS;
   localparam int unsigned CREDIT_W    = $clog2(MAX_CREDITS + 1);

   mc_req_s             in_req;
   logic                in_wr_v;
   logic                fifo_full;
   logic                send_fire;
   logic [CREDIT_W-1:0] credits_r;
   logic                out_v_r;
   mc_packet_s          out_packet_r;

   // receive path

   assign link_ready_o = ~fifo_full;
   assign in_wr_v      = link_v_i & link_ready_o;

   // op, byte mask and source are dropped here
   always_comb
   begin
      in_req.addr = link_packet_i.addr;
      in_req.data = link_packet_i.data;
   end

   mc_rx_fifo i_rx_fifo
   (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .wr_v_i    (in_wr_v),
      .wr_data_i (in_req),
      .full_o    (fifo_full),
      .rd_v_o    (req_v_o),
      .rd_data_o (req_o),
      .rd_yumi_i (req_yumi_i)
   );

   // credit counter

   assign send_ready_o = (credits_r != '0);
   assign send_fire    = send_v_i & send_ready_o;

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
         credits_r <= CREDIT_W'(MAX_CREDITS);
      else
      begin
         // a send and a returned credit in one cycle cancel out
         case ({send_fire, credit_i})
            2'b10:   credits_r <= credits_r - 1'b1;
            2'b01:   credits_r <= credits_r + 1'b1;
            default: credits_r <= credits_r;
         endcase
      end
   end

   // output register

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
         out_v_r <= 1'b0;
      else
         out_v_r <= send_fire;
   end

   always_ff @(posedge clk_i)
   begin
      if (send_fire)
         out_packet_r <= send_packet_i;
   end

   assign link_v_o      = out_v_r;
   assign link_packet_o = out_packet_r;

endmodule

`default_nettype wire

//--- src/mc_rx_fifo.sv
`timescale 1ns/10ps
`default_nettype none

`include "mc_accel_params.svh"

module mc_rx_fifo
(
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  wr_v_i,
   input  mc_accel_pkg::mc_req_s wr_data_i,
   output logic                  full_o,
   output logic                  rd_v_o,
   output mc_accel_pkg::mc_req_s rd_data_o,
   input  logic                  rd_yumi_i
);
   import mc_accel_pkg::*;

   localparam int unsigned ELS   = `MC_RX_FIFO_ELS;
   localparam int unsigned PTR_W = (ELS > 1) ? $clog2(ELS) : 1;
   localparam int unsigned CNT_W = $clog2(ELS + 1);

   mc_req_s          mem_r [ELS];
   logic [PTR_W-1:0] wr_ptr_r;
   logic [PTR_W-1:0] rd_ptr_r;
   logic [CNT_W-1:0] count_r;
   logic             push;
   logic             pop;

   // wraps at the last entry, so the depth need not be a power of two
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      logic [PTR_W-1:0] nxt;
      if (ptr == PTR_W'(ELS - 1))
         nxt = '0;
      else
         nxt = ptr + 1'b1;
      return nxt;
   endfunction

   assign full_o    = (count_r == CNT_W'(ELS));
   assign rd_v_o    = (count_r != '0);
   assign rd_data_o = mem_r[rd_ptr_r];

   assign pop  = rd_yumi_i & rd_v_o;
   // a full FIFO still takes a write when the head leaves in the same cycle
   assign push = wr_v_i & (~full_o | pop);

   always_ff @(posedge clk_i)
   begin
      if (push)
         mem_r[wr_ptr_r] <= wr_data_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr_r <= '0;
         rd_ptr_r <= '0;
         count_r  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr_r <= next_ptr(wr_ptr_r);
         if (pop)
            rd_ptr_r <= next_ptr(rd_ptr_r);
         case ({push, pop})
            2'b10:   count_r <= count_r + 1'b1;
            2'b01:   count_r <= count_r - 1'b1;
            default: count_r <= count_r;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- tb/mc_accel_chk.sv
`timescale 1ns/10ps
`default_nettype none

`include "mc_accel_params.svh"

module mc_accel_chk
(
   input logic clk_i,
   input logic rst_n_i,
   input logic link_v_i,
   input logic credit_i,
   input logic req_v_i,
   input logic req_yumi_i,
   input logic send_v_i,
   input logic send_ready_i
);
   localparam int unsigned MAX_CREDITS = `MC_MAX_CREDITS;

   // strobes seen on the output link and not yet paid back
   logic [3:0] out_cnt_r;
   // sends taken by the endpoint and not yet paid back
   logic [3:0] inflight_r;
   logic       send_fire;

   assign send_fire = send_v_i & send_ready_i;

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         out_cnt_r  <= '0;
         inflight_r <= '0;
      end
      else
      begin
         out_cnt_r  <= out_cnt_r + 4'(link_v_i) - 4'(credit_i);
         inflight_r <= inflight_r + 4'(send_fire) - 4'(credit_i);
      end
   end

   a_strobe_within_credits: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      link_v_i |-> (out_cnt_r < 4'(MAX_CREDITS)))
      else $error("output store beyond the credit limit");

   a_credit_below_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      credit_i |-> (inflight_r != '0))
      else $error("credit returned while the counter is full");

   a_yumi_with_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      req_yumi_i |-> req_v_i)
      else $error("FIFO head taken while not valid");

   a_one_strobe_per_send: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      link_v_i |-> $past(send_fire))
      else $error("output strobe without a send in the cycle before");

endmodule

bind mc_accel_tile mc_accel_chk i_chk
(
   .clk_i        (clk_i),
   .rst_n_i      (rst_n_i),
   .link_v_i     (link_v_o),
   .credit_i     (credit_i),
   .req_v_i      (req_v),
   .req_yumi_i   (req_yumi),
   .send_v_i     (send_v),
   .send_ready_i (send_ready)
);

`default_nettype wire

//--- tb/mc_accel_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "mc_accel_params.svh"

module mc_accel_tb;
   import mc_accel_pkg::*;

   localparam int RANDOM_PKTS    = 200;
   localparam int PKT_COUNT      = RANDOM_PKTS + 40;
   localparam int CYCLES_PER_PKT = 40;
   localparam int MAX_CYCLES     = PKT_COUNT * CYCLES_PER_PKT;
   localparam int MAX_CREDITS    = `MC_MAX_CREDITS;

   logic       clk_i;
   logic       rst_n_i;
   logic       link_v_i;
   mc_packet_s link_packet_i;
   logic       link_ready_o;
   logic       link_v_o;
   mc_packet_s link_packet_o;
   logic       credit_i;
   mc_cord_s   my_cord_i;
   logic       freeze_o;

   logic [31:0]               lfsr_r = 32'h76c2;
   mc_packet_s                exp_q [$];
   logic [`MC_ADDR_WIDTH-1:0] m_addr;
   mc_cord_s                  m_cord;
   logic                      m_freeze;
   bit                        auto_credit;
   int outstanding = 0;
   int out_count   = 0;
   int cycle_count = 0;
   int checks      = 0;
   int errors      = 0;
   int test_errors = 0;

   mc_accel_tile i_dut (.*);

   initial
   begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   always @(posedge clk_i)
      cycle_count <= cycle_count + 1;

   initial
   begin : watchdog
      wait (cycle_count >= MAX_CYCLES);
      $display("timeout: no progress within %0d cycles", MAX_CYCLES);
      $display("TB FAILED");
      $finish;
   end

   // taps 32, 22, 2, 1
   function logic lfsr_bit();
      lfsr_r = {lfsr_r[30:0], lfsr_r[31] ^ lfsr_r[21] ^ lfsr_r[1] ^ lfsr_r[0]};
      return lfsr_r[0];
   endfunction

   function logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
         v = {v[30:0], lfsr_bit()};
      return v;
   endfunction

   task check_value(input string name, input logic [127:0] exp, input logic [127:0] act);
      checks++;
      if (exp !== act)
      begin
         errors++;
         $display("FAILED %0d ns: %s expected %0h actual %0h", $time, name, exp, act);
      end
   endtask

   // stores come out in acceptance order with the config of that moment
   task model_accept(input logic [`MC_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
      mc_packet_s p;
      case (addr[1:0])
         2'd0: m_addr = data[`MC_ADDR_WIDTH-1:0];
         2'd1: m_cord = data[`MC_Y_WIDTH+`MC_X_WIDTH-1:0];
         2'd2:
         begin
            p = '{op: MC_OP_STORE, op_ex: 4'hf, addr: m_addr, data: data,
                  y_cord: m_cord.y_cord, x_cord: m_cord.x_cord,
                  src_y: my_cord_i.y_cord, src_x: my_cord_i.x_cord};
            exp_q.push_back(p);
         end
         default: m_freeze = data[0];
      endcase
   endtask

   // credits only go back for stores already seen, so the counter never overflows
   task next_cycle(input bit credit_now);
      @(posedge clk_i);
      #2;
      credit_i = credit_now;
      if (auto_credit && outstanding > 0 && rand_bits(2) == 2'd0)
         credit_i = 1'b1;
      if (credit_i)
         outstanding--;
   endtask

   task write_register(input logic [1:0] sel, input logic [31:0] data);
      mc_packet_s p;
      bit         taken;
      // op, byte mask and cords are junk that the tile must ignore
      p       = mc_packet_s'(rand_bits(32));
      p.op_ex = rand_bits(4);
      p.addr  = {rand_bits(`MC_ADDR_WIDTH - 2), sel};
      p.data  = data;
      link_v_i      = 1'b1;
      link_packet_i = p;
      taken         = 1'b0;
      while (!taken)
      begin
         taken = link_ready_o;
         next_cycle(1'b0);
      end
      link_v_i = 1'b0;
      model_accept(p.addr, data);
   endtask

   task idle_cycles(input int n);
      repeat (n) next_cycle(1'b0);
   endtask

   task wait_outputs(input int target);
      while (out_count < target)
         next_cycle(1'b0);
   endtask

   task wait_drain();
      while (exp_q.size() != 0)
         next_cycle(1'b0);
   endtask

   task return_credits();
      while (outstanding > 0)
         next_cycle(1'b1);
      next_cycle(1'b0);
   endtask

   task apply_reset();
      rst_n_i  = 1'b0;
      link_v_i = 1'b0;
      credit_i = 1'b0;
      repeat (16) @(posedge clk_i);
      #2;
      rst_n_i = 1'b1;
      exp_q.delete();
      outstanding = 0;
      m_addr      = '0;
      m_cord      = '0;
      m_freeze    = 1'b1;
   endtask

   task end_test(input string name);
      $display("test %s done, %0d errors", name, errors - test_errors);
      test_errors = errors;
   endtask

   always @(negedge clk_i)
   begin
      if (rst_n_i && link_v_o)
      begin
         out_count++;
         outstanding++;
         if (exp_q.size() == 0)
         begin
            errors++;
            $display("ERROR %0d ns: a store left the tile when none was expected", $time);
         end
         else
            check_value("link_packet_o", exp_q.pop_front(), link_packet_o);
      end
   end

   initial
   begin
      int          base;
      int          stores;
      logic [1:0]  sel;
      logic [31:0] data;
      rst_n_i       = 1'b0;
      link_v_i      = 1'b0;
      link_packet_i = '0;
      credit_i      = 1'b0;
      my_cord_i     = '{y_cord: 4'h3, x_cord: 4'h5};
      auto_credit   = 1'b0;
      apply_reset();
      check_value("link_v_o", 1'b0, link_v_o);
      check_value("link_ready_o", 1'b1, link_ready_o);
      check_value("freeze_o", m_freeze, freeze_o);
      end_test("reset");

      auto_credit = 1'b1;
      write_register(2'd3, 32'h0);
      write_register(2'd0, rand_bits(32));
      write_register(2'd1, rand_bits(32));
      repeat (4) write_register(2'd2, rand_bits(32));
      write_register(2'd0, rand_bits(32));
      write_register(2'd1, rand_bits(32));
      repeat (2) write_register(2'd2, rand_bits(32));
      wait_drain();
      check_value("freeze_o", m_freeze, freeze_o);
      return_credits();
      end_test("forwarding");

      // a frozen head is never released by a later clear, only by reset
      write_register(2'd3, 32'h1);
      base = out_count;
      repeat (4) write_register(2'd2, rand_bits(32));
      check_value("link_ready_o", 1'b0, link_ready_o);
      idle_cycles(10);
      check_value("link_v_o strobes", base, out_count);
      check_value("freeze_o", m_freeze, freeze_o);
      apply_reset();
      check_value("link_ready_o", 1'b1, link_ready_o);
      // credit stall holds the head while config writes fill the FIFO
      auto_credit = 1'b0;
      write_register(2'd3, 32'h0);
      write_register(2'd0, rand_bits(32));
      write_register(2'd1, rand_bits(32));
      base = out_count;
      repeat (MAX_CREDITS + 1) write_register(2'd2, rand_bits(32));
      wait_outputs(base + MAX_CREDITS);
      write_register(2'd0, rand_bits(32));
      write_register(2'd1, rand_bits(32));
      write_register(2'd2, rand_bits(32));
      check_value("link_ready_o", 1'b0, link_ready_o);
      auto_credit = 1'b1;
      wait_drain();
      return_credits();
      end_test("freeze and back-pressure");

      auto_credit = 1'b0;
      base        = out_count;
      repeat (MAX_CREDITS + 2) write_register(2'd2, rand_bits(32));
      wait_outputs(base + MAX_CREDITS);
      idle_cycles(10);
      check_value("link_v_o strobes", base + MAX_CREDITS, out_count);
      for (int k = 1; k <= 2; k++)
      begin
         next_cycle(1'b1);
         wait_outputs(base + MAX_CREDITS + k);
         idle_cycles(10);
         check_value("link_v_o strobes", base + MAX_CREDITS + k, out_count);
      end
      return_credits();
      end_test("credits");

      auto_credit = 1'b1;
      base        = out_count;
      stores      = 0;
      for (int n = 0; n < RANDOM_PKTS; n++)
      begin
         sel  = rand_bits(2);
         data = rand_bits(32);
         // keep freeze clear so no store gets stuck at the head
         if (sel == 2'd3)
            data[0] = 1'b0;
         if (sel == 2'd2)
            stores++;
         write_register(sel, data);
         if (rand_bits(2) == 2'd0)
            idle_cycles(rand_bits(2) + 1);
      end
      wait_drain();
      idle_cycles(10);
      check_value("link_v_o strobes", base + stores, out_count);
      end_test("random mix");

      $display("checks %0d, errors %0d, stores %0d", checks, errors, out_count);
      if (errors == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

`default_nettype wire
